// ==== adc_path/adc_path.sv ====
`timescale 1ns/100ps
`default_nettype none

module adc_path (
	input  logic                   clk1,
	input  logic                   i_rst_n,
	input  config_pkg::cfg_word_t  i_cfg,
	input  servo_pkg::adc_sample_t i_adc,
	output servo_pkg::filt_out_t   o_filt
);

	// per-channel raw samples
	logic signed [servo_pkg::ADC_W-1:0] x [2];
	// filter outputs
	logic signed [servo_pkg::SIG_W-1:0] y [2];
	logic                               y_valid [2];
	// aligned output stage
	logic                               filt_valid;
	logic signed [servo_pkg::SIG_W-1:0] ch0_q;
	logic signed [servo_pkg::SIG_W-1:0] ch1_q;
	logic signed [servo_pkg::SIG_W-1:0] diff_q;

	assign x[0] = i_adc.ch0;
	assign x[1] = i_adc.ch1;

	////////////////////
	// low-pass filters
	////////////////////

	// both channels share the input valid
	generate
		for (genvar g = 0; g < 2; g++) begin : g_chan
			iir_first_order u_iir (
				.clk1    (clk1),
				.i_rst_n (i_rst_n),
				.i_coef  (i_cfg.ch[g].coef),
				.i_valid (i_adc.valid),
				.i_x     (x[g]),
				.o_valid (y_valid[g]),
				.o_y     (y[g])
			);
		end
	endgenerate

	////////////////////
	// output stage
	////////////////////

	// third cycle, valid only
	always_ff @(posedge clk1) begin
		if (!i_rst_n) begin
			filt_valid <= 1'b0;
		end else begin
			filt_valid <= y_valid[0];
		end
	end

	// channel copies and difference registered together
	// diff wraps to SIG_W
	always_ff @(posedge clk1) begin
		if (y_valid[0]) begin
			ch0_q  <= y[0];
			ch1_q  <= y[1];
			diff_q <= y[0] - y[1];
		end
	end

	assign o_filt.valid = filt_valid;
	assign o_filt.ch0   = ch0_q;
	assign o_filt.ch1   = ch1_q;
	assign o_filt.diff  = diff_q;

	// channels must stay in lockstep for the difference to mean anything
	a_chan_lockstep: assert property (@(posedge clk1) disable iff (!i_rst_n)
		y_valid[0] == y_valid[1]);

endmodule

`default_nettype wire

// ==== adc_path/iir_first_order.sv ====
`timescale 1ns/100ps
`default_nettype none

module iir_first_order (
	input  logic                               clk1,
	input  logic                               i_rst_n,
	input  servo_pkg::iir_coef_t               i_coef,
	input  logic                               i_valid,
	input  logic signed [servo_pkg::ADC_W-1:0] i_x,
	output logic                               o_valid,
	output logic signed [servo_pkg::SIG_W-1:0] o_y
);

	// product width plus headroom for the three-term sum
	localparam int ACC_W = servo_pkg::COEF_W + servo_pkg::SIG_W + 2;

	// sample placed in the upper bits
	logic signed [servo_pkg::SIG_W-1:0] x_w;
	logic signed [servo_pkg::SIG_W-1:0] x_prev;
	// stage 1
	logic                               v_s1;
	logic signed [ACC_W-1:0]            ff_s1;
	logic signed [servo_pkg::SIG_W-1:0] x_s1;
	// stage 2
	logic signed [ACC_W-1:0]            acc;
	logic signed [servo_pkg::SIG_W-1:0] y_new;
	logic signed [servo_pkg::SIG_W-1:0] y_prev;
	logic                               v_s2;

	assign x_w = {i_x, {(servo_pkg::SIG_W - servo_pkg::ADC_W){1'b0}}};

	////////////////////
	// stage 1
	////////////////////

	// x history moves on valid samples only
	always_ff @(posedge clk1) begin
		if (!i_rst_n) begin
			x_prev <= '0;
			v_s1   <= 1'b0;
		end else begin
			v_s1 <= i_valid;
			if (i_valid) begin
				x_prev <= x_w;
			end
		end
	end

	// feed-forward products b0*x + b1*x_prev
	always_ff @(posedge clk1) begin
		if (i_valid) begin
			ff_s1 <= i_coef.b0 * x_w + i_coef.b1 * x_prev;
			x_s1  <= x_w;
		end
	end

	////////////////////
	// stage 2
	////////////////////

	// add feedback, shift out the fraction, wrap to SIG_W
	always_comb begin
		acc   = ff_s1 + i_coef.a1 * y_prev;
		y_new = i_coef.on ? acc[servo_pkg::COEF_FRAC +: servo_pkg::SIG_W] : x_s1;
	end

	// y_prev is also the output register
	// one cycle loop, so back-to-back samples are fine
	always_ff @(posedge clk1) begin
		if (!i_rst_n) begin
			y_prev <= '0;
			v_s2   <= 1'b0;
		end else begin
			v_s2 <= v_s1;
			if (v_s1) begin
				y_prev <= y_new;
			end
		end
	end

	assign o_valid = v_s2;
	assign o_y     = y_prev;

	// fixed two-cycle latency once out of reset
	a_latency: assert property (@(posedge clk1)
		(i_rst_n && $past(i_rst_n) && $past(i_rst_n, 2)) |-> (o_valid == $past(i_valid, 2)));

endmodule

`default_nettype wire

// ==== common/config_pkg.sv ====
`default_nettype none

package config_pkg;

	////////////////////
	// config word
	////////////////////

	// full width of the configuration word
	localparam int CFG_W = 128;

	// settings for one adc channel
	typedef struct packed {
		// low-pass filter coefficients
		servo_pkg::iir_coef_t coef;
		// front-end amp gain x10 select
		logic                 gainx10;
		// front-end amp power down
		logic                 power_down;
	} chan_cfg_t;

	// unused upper bits of the word
	localparam int CFG_PAD_W = CFG_W - 2 * $bits(chan_cfg_t);

	// channel 0 in the low bits
	typedef struct packed {
		logic [CFG_PAD_W-1:0] pad;
		chan_cfg_t [1:0]      ch;
	} cfg_word_t;

	////////////////////
	// front-end pins
	////////////////////

	// bit n belongs to adc channel n
	typedef struct packed {
		logic [1:0] gainx10;
		// active low shutdown
		logic [1:0] nshdn;
	} afe_ctrl_t;

endpackage

`default_nettype wire

// ==== common/servo_pkg.sv ====
`default_nettype none

package servo_pkg;

	////////////////////
	// signal widths
	////////////////////

	// raw adc sample width
	localparam int ADC_W = 16;
	// internal signal width after widening
	localparam int SIG_W = 24;
	// iir coefficients, signed fixed point
	localparam int COEF_W = 18;
	localparam int COEF_FRAC = 16;

	// raw sample pair, already deserialized
	typedef struct packed {
		logic                    valid;
		logic signed [ADC_W-1:0] ch0;
		logic signed [ADC_W-1:0] ch1;
	} adc_sample_t;

	// adc path result, all fields aligned
	typedef struct packed {
		logic                    valid;
		logic signed [SIG_W-1:0] ch0;
		logic signed [SIG_W-1:0] ch1;
		logic signed [SIG_W-1:0] diff;
	} filt_out_t;

	// first-order iir, on clear means bypass
	typedef struct packed {
		logic                     on;
		logic signed [COEF_W-1:0] a1;
		logic signed [COEF_W-1:0] b0;
		logic signed [COEF_W-1:0] b1;
	} iir_coef_t;

	////////////////////
	// slow dac frame
	////////////////////

	// dac resolution, top bits of the servo word
	localparam int DAC_DATA_W = 20;
	// write-and-update command ahead of the data
	localparam logic [3:0] DAC_HDR = 4'b0011;
	localparam int DAC_FRAME_W = $bits(DAC_HDR) + DAC_DATA_W;
	// clk1 cycles per sck half period
	localparam int SCK_HALF = 2;
	// serializer buffer depth, also the sender's credits
	localparam int DAC_CREDITS = 2;

	typedef struct packed {
		logic                    valid;
		logic signed [SIG_W-1:0] data;
	} dac_word_t;

	typedef struct packed {
		logic cs_n;
		logic sck;
		logic sdo;
	} spi_t;

endpackage

`default_nettype wire

// ==== dac_spi/dac_spi_serializer.sv ====
`timescale 1ns/100ps
`default_nettype none

module dac_spi_serializer (
	input  logic                 clk1,
	input  logic                 i_rst_n,
	input  servo_pkg::dac_word_t i_dac,
	output logic                 o_credit,
	output servo_pkg::spi_t      o_spi,
	output logic                 o_ldac_n
);

	localparam int PTR_W  = (servo_pkg::DAC_CREDITS > 1) ? $clog2(servo_pkg::DAC_CREDITS) : 1;
	localparam int FILL_W = $clog2(servo_pkg::DAC_CREDITS + 1);
	localparam int HALF_W = (servo_pkg::SCK_HALF > 1) ? $clog2(servo_pkg::SCK_HALF) : 1;
	localparam int BIT_W  = $clog2(servo_pkg::DAC_FRAME_W);

	typedef enum logic [1:0] {ST_IDLE, ST_SHIFT, ST_LOAD} state_t;

	// word buffer, only the bits the dac takes
	logic [servo_pkg::DAC_DATA_W-1:0]  buf_mem [servo_pkg::DAC_CREDITS];
	logic [PTR_W-1:0]                  wr_ptr;
	logic [PTR_W-1:0]                  rd_ptr;
	logic [FILL_W-1:0]                 fill;
	logic                              push;
	logic                              pop;
	// frame shifter
	state_t                            state;
	logic [servo_pkg::DAC_FRAME_W-1:0] shreg;
	logic [HALF_W-1:0]                 half_cnt;
	logic [BIT_W-1:0]                  bit_cnt;
	logic                              half_end;
	// registered pins
	logic                              cs_n_q;
	logic                              sck_q;
	logic                              ldac_n_q;
	logic                              credit_q;

	assign push     = i_dac.valid;
	// pop only between frames
	assign pop      = (state == ST_IDLE) && (fill != '0);
	assign half_end = (half_cnt == HALF_W'(servo_pkg::SCK_HALF - 1));

	////////////////////
	// credit buffer
	////////////////////

	always_ff @(posedge clk1) begin
		if (push) begin
			buf_mem[wr_ptr] <= i_dac.data[servo_pkg::SIG_W-1 -: servo_pkg::DAC_DATA_W];
		end
	end

	always_ff @(posedge clk1) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(servo_pkg::DAC_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(servo_pkg::DAC_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	////////////////////
	// frame fsm
	////////////////////

	always_ff @(posedge clk1) begin
		if (!i_rst_n) begin
			state    <= ST_IDLE;
			shreg    <= '0;
			half_cnt <= '0;
			bit_cnt  <= '0;
			cs_n_q   <= 1'b1;
			sck_q    <= 1'b0;
			ldac_n_q <= 1'b1;
			credit_q <= 1'b0;
		end else begin
			// single-cycle pulses by default
			credit_q <= 1'b0;
			ldac_n_q <= 1'b1;
			case (state)
				ST_IDLE: begin
					if (pop) begin
						// header first, then data msb first
						shreg    <= {servo_pkg::DAC_HDR, buf_mem[rd_ptr]};
						credit_q <= 1'b1;
						cs_n_q   <= 1'b0;
						sck_q    <= 1'b0;
						half_cnt <= '0;
						bit_cnt  <= '0;
						state    <= ST_SHIFT;
					end
				end
				ST_SHIFT: begin
					if (!half_end) begin
						half_cnt <= half_cnt + 1'b1;
					end else begin
						half_cnt <= '0;
						if (!sck_q) begin
							// dac samples sdo here
							sck_q <= 1'b1;
						end else begin
							sck_q <= 1'b0;
							if (bit_cnt == BIT_W'(servo_pkg::DAC_FRAME_W - 1)) begin
								cs_n_q <= 1'b1;
								state  <= ST_LOAD;
							end else begin
								// next bit goes out on the falling edge
								bit_cnt <= bit_cnt + 1'b1;
								shreg   <= {shreg[servo_pkg::DAC_FRAME_W-2:0], 1'b0};
							end
						end
					end
				end
				ST_LOAD: begin
					// latch the new code into the dac output
					ldac_n_q <= 1'b0;
					state    <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign o_spi.cs_n = cs_n_q;
	assign o_spi.sck  = sck_q;
	assign o_spi.sdo  = shreg[servo_pkg::DAC_FRAME_W-1];
	assign o_ldac_n   = ldac_n_q;
	assign o_credit   = credit_q;

	// sender overran its credits
	a_no_overflow: assert property (@(posedge clk1) disable iff (!i_rst_n)
		i_dac.valid |-> (fill < FILL_W'(servo_pkg::DAC_CREDITS)));

	// ldac only outside a frame
	a_ldac_idle: assert property (@(posedge clk1) disable iff (!i_rst_n)
		!o_ldac_n |-> o_spi.cs_n);

endmodule

`default_nettype wire

// ==== rtl/config_capture.sv ====
`timescale 1ns/100ps
`default_nettype none

module config_capture (
	input  logic                  clk1,
	input  logic                  i_rst_n,
	input  config_pkg::cfg_word_t i_cfg,
	output config_pkg::cfg_word_t o_cfg,
	output config_pkg::afe_ctrl_t o_afe
);

	// registered copy of the config word
	config_pkg::cfg_word_t cfg_q;
	// amp control pins
	config_pkg::afe_ctrl_t afe_q;

	////////////////////
	// config register
	////////////////////

	// slow config source enters clk1 through one stage
	always_ff @(posedge clk1) begin
		if (!i_rst_n) begin
			// filters come up in bypass
			cfg_q <= '0;
		end else begin
			cfg_q <= i_cfg;
		end
	end

	////////////////////
	// amp controls
	////////////////////

	// one more stage to the pins
	// reset keeps both amps shut down at gain x1
	always_ff @(posedge clk1) begin
		if (!i_rst_n) begin
			afe_q.gainx10 <= '0;
			afe_q.nshdn   <= '0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				afe_q.gainx10[i] <= cfg_q.ch[i].gainx10;
				// power-down bit is the inverse of nshdn
				afe_q.nshdn[i]   <= ~cfg_q.ch[i].power_down;
			end
		end
	end

	assign o_cfg = cfg_q;
	assign o_afe = afe_q;

endmodule

`default_nettype wire

// ==== rtl/servo_frontend.sv ====
`timescale 1ns/100ps
`default_nettype none

module servo_frontend (
	input  logic                   clk1,
	input  logic                   i_rst_n,
	input  config_pkg::cfg_word_t  i_cfg,
	input  servo_pkg::adc_sample_t i_adc,
	input  servo_pkg::dac_word_t   i_dac,
	output config_pkg::afe_ctrl_t  o_afe,
	output servo_pkg::filt_out_t   o_filt,
	output servo_pkg::spi_t        o_spi,
	output logic                   o_ldac_n,
	output logic                   o_dac_credit
);

	// config word after the input register
	config_pkg::cfg_word_t cfg_q;

	////////////////////
	// configuration
	////////////////////

	// also drives the amp gain and shutdown pins
	config_capture u_config_capture (
		.clk1    (clk1),
		.i_rst_n (i_rst_n),
		.i_cfg   (i_cfg),
		.o_cfg   (cfg_q),
		.o_afe   (o_afe)
	);

	////////////////////
	// adc path
	////////////////////

	// filters read coefficients from the registered word
	adc_path u_adc_path (
		.clk1    (clk1),
		.i_rst_n (i_rst_n),
		.i_cfg   (cfg_q),
		.i_adc   (i_adc),
		.o_filt  (o_filt)
	);

	////////////////////
	// slow dac
	////////////////////

	// credit return goes straight back to the sender
	dac_spi_serializer u_dac_spi_serializer (
		.clk1     (clk1),
		.i_rst_n  (i_rst_n),
		.i_dac    (i_dac),
		.o_credit (o_dac_credit),
		.o_spi    (o_spi),
		.o_ldac_n (o_ldac_n)
	);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the servo_frontend testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_servo_frontend \
	-f servo_frontend.f -o sim_servo_frontend &&
	./obj_dir/sim_servo_frontend > sim.log 2>&1
cat sim.log 2>/dev/null
# no log, or the fail message in it, means failure
test -f sim.log && ! grep -q "CHECKS FAILED" sim.log && grep -q "ALL CHECKS PASSED" sim.log &&
	echo "simulation passed" && exit 0 || { echo "simulation failed"; exit 1; }

// ==== servo_frontend.f ====
common/servo_pkg.sv
common/config_pkg.sv
rtl/config_capture.sv
adc_path/iir_first_order.sv
adc_path/adc_path.sv
dac_spi/dac_spi_serializer.sv
rtl/servo_frontend.sv
sim/tb_servo_frontend.sv

// ==== sim/tb_servo_frontend.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_servo_frontend;

	// stimulus lengths and run limit
	localparam int N_AFE      = 8;
	localparam int N_BYPASS   = 100;
	localparam int N_ACTIVE   = 100;
	localparam int N_WORDS    = 20;
	localparam int MAX_CYCLES = 4000;

	logic                   clk1;
	logic                   i_rst_n;
	config_pkg::cfg_word_t  i_cfg;
	servo_pkg::adc_sample_t i_adc;
	servo_pkg::dac_word_t   i_dac;
	config_pkg::afe_ctrl_t  o_afe;
	servo_pkg::filt_out_t   o_filt;
	servo_pkg::spi_t        o_spi;
	logic                   o_ldac_n;
	logic                   o_dac_credit;

	// run bookkeeping
	string                              test_name;
	int                                 cycles;
	int                                 hi_edges;
	int                                 words_sent;
	// iir reference state, one entry per channel
	logic signed [servo_pkg::SIG_W-1:0] x_prev [2];
	logic signed [servo_pkg::SIG_W-1:0] y_prev [2];
	// expected outputs, delayed to the dut latency
	servo_pkg::filt_out_t               exp_filt [3];
	config_pkg::afe_ctrl_t              exp_afe [2];
	// spi frame collector and credit counter
	logic [servo_pkg::DAC_FRAME_W-1:0]  frame_q [$];
	logic [servo_pkg::DAC_FRAME_W-1:0]  shift_in;
	logic [servo_pkg::DAC_FRAME_W-1:0]  got_frame;
	logic [servo_pkg::DAC_FRAME_W-1:0]  exp_frame;
	int                                 bit_cnt;
	int                                 frames;
	int                                 ldac_pulses;
	int                                 credits;
	logic                               frame_done;
	logic                               extra_frame;
	logic                               partial;
	logic                               sck_last;
	logic                               ldac_last;

	servo_frontend dut (
		.clk1         (clk1),
		.i_rst_n      (i_rst_n),
		.i_cfg        (i_cfg),
		.i_adc        (i_adc),
		.i_dac        (i_dac),
		.o_afe        (o_afe),
		.o_filt       (o_filt),
		.o_spi        (o_spi),
		.o_ldac_n     (o_ldac_n),
		.o_dac_credit (o_dac_credit)
	);

	////////////////////
	// error reporting
	////////////////////

	task automatic abort_run();
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string test, input longint expv, input longint actv);
		$display("Fail %s expected %0d actual %0d", test, expv, actv);
		abort_run();
	endtask

	task automatic report_problem(input string what);
		$display("%s", what);
		abort_run();
	endtask

	// raw sample into the upper bits of the signal width
	function automatic logic signed [servo_pkg::SIG_W-1:0] widen(
		input logic signed [servo_pkg::ADC_W-1:0] x);
		return {x, {(servo_pkg::SIG_W - servo_pkg::ADC_W){1'b0}}};
	endfunction

	// y = (b0*x + b1*x_prev + a1*y_prev) >>> COEF_FRAC, wrapped
	function automatic logic signed [servo_pkg::SIG_W-1:0] iir_rule(
		input servo_pkg::iir_coef_t c, input logic signed [servo_pkg::SIG_W-1:0] x,
		input logic signed [servo_pkg::SIG_W-1:0] xp, input logic signed [servo_pkg::SIG_W-1:0] yp);
		longint sum;
		if (!c.on) begin
			return x;
		end
		sum = longint'(c.b0) * longint'(x) + longint'(c.b1) * longint'(xp)
			+ longint'(c.a1) * longint'(yp);
		return sum[servo_pkg::COEF_FRAC +: servo_pkg::SIG_W];
	endfunction

	// drive point, 5 ns after the nth rising edge
	task automatic advance(input int n);
		repeat (n) @(posedge clk1);
		#5;
	endtask

	initial begin
		clk1 = 1'b0;
		forever #20 clk1 = ~clk1;
	end

	always @(posedge clk1) begin
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, the dut stopped responding", MAX_CYCLES);
			abort_run();
		end
	end

	////////////////////
	// reference models
	////////////////////

	// iir model runs at the input, then a 3 stage delay line
	always @(posedge clk1) begin : adc_model
		logic signed [servo_pkg::ADC_W-1:0] x_in [2];
		logic signed [servo_pkg::SIG_W-1:0] y_out [2];
		servo_pkg::filt_out_t               nxt;
		x_in[0] = i_adc.ch0;
		x_in[1] = i_adc.ch1;
		nxt     = '0;
		for (int i = 0; i < 2; i++) begin
			y_out[i] = iir_rule(i_cfg.ch[i].coef, widen(x_in[i]), x_prev[i], y_prev[i]);
			if (!i_rst_n) begin
				x_prev[i] = '0;
				y_prev[i] = '0;
			end else if (i_adc.valid) begin
				// history moves on valid samples only
				x_prev[i] = widen(x_in[i]);
				y_prev[i] = y_out[i];
			end
		end
		if (i_rst_n && i_adc.valid) begin
			nxt.valid = 1'b1;
			nxt.ch0   = y_out[0];
			nxt.ch1   = y_out[1];
			nxt.diff  = y_out[0] - y_out[1];
		end
		exp_filt[0] <= nxt;
		exp_filt[1] <= exp_filt[0];
		exp_filt[2] <= exp_filt[1];
	end

	// amp pins follow the config two cycles later
	always @(posedge clk1) begin
		exp_afe[0].gainx10 <= {i_cfg.ch[1].gainx10, i_cfg.ch[0].gainx10};
		exp_afe[0].nshdn   <= ~{i_cfg.ch[1].power_down, i_cfg.ch[0].power_down};
		exp_afe[1]         <= exp_afe[0];
	end

	// credit counter, sdo collector, ldac pulse count
	always @(posedge clk1) begin
		cycles     <= cycles + 1;
		frame_done <= 1'b0;
		ldac_last  <= o_ldac_n;
		sck_last   <= o_spi.sck;
		if (!i_rst_n) begin
			credits     <= servo_pkg::DAC_CREDITS;
			bit_cnt     <= 0;
			partial     <= 1'b0;
			extra_frame <= 1'b0;
		end else begin
			hi_edges <= hi_edges + 1;
			credits  <= credits - int'(i_dac.valid) + int'(o_dac_credit);
			if (!o_ldac_n) begin
				ldac_pulses <= ldac_pulses + 1;
			end
			if (o_spi.cs_n) begin
				// cs_n back high with bits pending
				if (bit_cnt != 0) begin
					partial <= 1'b1;
				end
				bit_cnt <= 0;
			end else if (o_spi.sck && !sck_last) begin
				shift_in <= {shift_in[servo_pkg::DAC_FRAME_W-2:0], o_spi.sdo};
				if (bit_cnt == servo_pkg::DAC_FRAME_W - 1) begin
					got_frame  <= {shift_in[servo_pkg::DAC_FRAME_W-2:0], o_spi.sdo};
					frame_done <= 1'b1;
					frames     <= frames + 1;
					bit_cnt    <= 0;
					if (frame_q.size() == 0) begin
						extra_frame <= 1'b1;
					end else begin
						exp_frame <= frame_q.pop_front();
					end
				end else begin
					bit_cnt <= bit_cnt + 1;
				end
			end
		end
	end

	////////////////////
	// checks
	////////////////////

	// all checks sample mid-cycle, away from the drive point
	a_reset_state: assert property (@(negedge clk1) disable iff (cycles < 1)
		(hi_edges == 0) |-> (!o_filt.valid && !o_dac_credit && o_afe.nshdn == 2'b00
			&& o_spi.cs_n && o_ldac_n && !o_spi.sck))
		else report_problem("reset: outputs left their reset state too early");
	a_filt_valid: assert property (@(negedge clk1) disable iff (cycles < 3)
		o_filt.valid == exp_filt[2].valid)
		else report_mismatch({test_name, "_valid"}, exp_filt[2].valid, o_filt.valid);
	a_filt_ch0: assert property (@(negedge clk1) disable iff (cycles < 3)
		exp_filt[2].valid |-> o_filt.ch0 == exp_filt[2].ch0)
		else report_mismatch({test_name, "_ch0"}, exp_filt[2].ch0, o_filt.ch0);
	a_filt_ch1: assert property (@(negedge clk1) disable iff (cycles < 3)
		exp_filt[2].valid |-> o_filt.ch1 == exp_filt[2].ch1)
		else report_mismatch({test_name, "_ch1"}, exp_filt[2].ch1, o_filt.ch1);
	a_filt_diff: assert property (@(negedge clk1) disable iff (cycles < 3)
		exp_filt[2].valid |-> o_filt.diff == exp_filt[2].diff)
		else report_mismatch({test_name, "_diff"}, exp_filt[2].diff, o_filt.diff);
	a_afe: assert property (@(negedge clk1) disable iff (hi_edges < 2)
		o_afe == exp_afe[1])
		else report_mismatch("afe", longint'(exp_afe[1]), longint'(o_afe));
	a_frame: assert property (@(negedge clk1) disable iff (cycles < 1)
		frame_done |-> got_frame == exp_frame)
		else report_mismatch("dac_frame", exp_frame, got_frame);
	a_no_extra_frame: assert property (@(negedge clk1) disable iff (cycles < 1) !extra_frame)
		else report_problem("dac: a frame went out with no word waiting for it");
	a_whole_frame: assert property (@(negedge clk1) disable iff (cycles < 1) !partial)
		else report_problem("dac: cs_n rose before all frame bits were clocked");
	a_credit_range: assert property (@(negedge clk1) disable iff (cycles < 1)
		credits >= 0 && credits <= servo_pkg::DAC_CREDITS)
		else report_problem($sformatf("credits: counter left its range at %0d", credits));
	a_ldac_single: assert property (@(negedge clk1) disable iff (cycles < 2)
		!(!ldac_last && !o_ldac_n))
		else report_problem("dac: ldac_n stayed low for more than one cycle");
	a_ldac_after_frame: assert property (@(negedge clk1) disable iff (cycles < 1)
		!o_ldac_n |-> (o_spi.cs_n && ldac_pulses < frames))
		else report_problem("dac: ldac_n pulsed without a finished frame");

	////////////////////
	// stimulus
	////////////////////

	initial begin : stimulus
		logic [31:0] rnd;
		void'($urandom(36));
		i_rst_n     = 1'b0;
		i_cfg       = '0;
		i_adc       = '0;
		i_dac       = '0;
		test_name   = "reset";
		cycles      = 0;
		hi_edges    = 0;
		words_sent  = 0;
		frames      = 0;
		ldac_pulses = 0;
		advance(3);
		i_rst_n = 1'b1;

		// random gain and power-down bits, filters stay in bypass
		test_name = "afe";
		repeat (N_AFE) begin
			rnd = $urandom;
			i_cfg.ch[0].gainx10    = rnd[0];
			i_cfg.ch[0].power_down = rnd[1];
			i_cfg.ch[1].gainx10    = rnd[2];
			i_cfg.ch[1].power_down = rnd[3];
			advance(4);
		end

		// back to back samples through the bypass
		test_name = "bypass";
		for (int n = 0; n < N_BYPASS; n++) begin
			rnd         = $urandom;
			i_adc.valid = 1'b1;
			i_adc.ch0   = rnd[servo_pkg::ADC_W-1:0];
			i_adc.ch1   = rnd[2*servo_pkg::ADC_W-1 -: servo_pkg::ADC_W];
			advance(1);
		end
		i_adc.valid = 1'b0;
		advance(6);

		// random coefficients, settle before samples
		test_name = "active";
		for (int i = 0; i < 2; i++) begin
			i_cfg.ch[i].coef.on = 1'b1;
			rnd = $urandom;
			i_cfg.ch[i].coef.a1 = rnd[servo_pkg::COEF_W-1:0];
			rnd = $urandom;
			i_cfg.ch[i].coef.b0 = rnd[servo_pkg::COEF_W-1:0];
			rnd = $urandom;
			i_cfg.ch[i].coef.b1 = rnd[servo_pkg::COEF_W-1:0];
		end
		advance(4);
		for (int n = 0; n < N_ACTIVE; n++) begin
			rnd         = $urandom;
			i_adc.valid = ($urandom_range(0, 3) != 0);
			i_adc.ch0   = rnd[servo_pkg::ADC_W-1:0];
			i_adc.ch1   = rnd[2*servo_pkg::ADC_W-1 -: servo_pkg::ADC_W];
			advance(1);
		end
		i_adc.valid = 1'b0;
		advance(6);

		// send on every free credit, pause now and then
		test_name = "dac";
		while (words_sent < N_WORDS) begin
			if (credits > 0 && $urandom_range(0, 3) != 0) begin
				rnd          = $urandom;
				i_dac.valid  = 1'b1;
				i_dac.data   = rnd[servo_pkg::SIG_W-1:0];
				frame_q.push_back({servo_pkg::DAC_HDR,
					i_dac.data[servo_pkg::SIG_W-1 -: servo_pkg::DAC_DATA_W]});
				words_sent++;
			end else begin
				i_dac.valid = 1'b0;
			end
			advance(1);
		end
		i_dac.valid = 1'b0;
		while (ldac_pulses < N_WORDS) begin
			advance(1);
		end
		advance(4);

		// one frame and one load pulse per word, all credits back
		assert (frames == N_WORDS) else report_mismatch("dac_frames", N_WORDS, frames);
		assert (ldac_pulses == N_WORDS) else report_mismatch("dac_ldac", N_WORDS, ldac_pulses);
		assert (credits == servo_pkg::DAC_CREDITS)
			else report_mismatch("dac_credits", servo_pkg::DAC_CREDITS, credits);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire
